// File: pipeline_tail.f
design/display_tail_pkg.sv
design/pulse_sync.sv
design/drawing_manager.sv
design/frame_buffer.sv
design/display_scanout.sv
design/pipeline_tail.sv
testbench/pipeline_tail_tb.sv

// File: Bender.yml
package:
  name: pipeline_tail

sources:
  - design/display_tail_pkg.sv
  - design/pulse_sync.sv
  - design/drawing_manager.sv
  - design/frame_buffer.sv
  - design/display_scanout.sv
  - design/pipeline_tail.sv
  - target: test
    files:
      - testbench/pipeline_tail_tb.sv

// File: testbench/pipeline_tail_tb.sv
`timescale 1ns/100ps

module pipeline_tail_tb;

    import display_tail_pkg::*;

    localparam int frame_count    = 5;
    localparam int display_period = 10;
    localparam int system_period  = 6;
    localparam int scan_cycles    = h_total * v_total;

    // Frames finished this close to a vsync edge may still miss that swap
    localparam int settle_time    = 20 * display_period;

    // Two scan frames counted in system cycles
    localparam int ack_limit      = (2 * scan_cycles * display_period + system_period - 1)
                                  / system_period;

    // Two scans per frame and for the debug view, one more for the last frame
    localparam int timeout_cycles = (2 * frame_count + 3) * scan_cycles;

    logic                   clk_system = 1'b0;
    logic                   clk_display = 1'b0;
    logic                   rstn_system;
    logic                   rstn_display;
    logic                   pixel_valid;
    logic                   pixel_ready;
    logic [color_width-1:0] pixel_color;
    logic [x_width-1:0]     pixel_x;
    logic [y_width-1:0]     pixel_y;
    logic                   pixel_last;
    logic                   debug_active_frame_buffer;
    logic                   vga_hsync;
    logic                   vga_vsync;
    logic                   screen_data_enable;
    logic [red_width-1:0]   vga_red;
    logic [green_width-1:0] vga_green;
    logic [blue_width-1:0]  vga_blue;

    // Every sent frame and the time its last pixel was accepted
    logic [color_width-1:0] model [frame_count][buf_depth];
    time                    done_time [frame_count];
    int                     frames_done = 0;

    logic [31:0] lfsr_state = 32'hf936_6f91;
    int          error_count = 0;
    int          checked_pixels = 0;
    int          debug_pixels = 0;
    int          vsync_edges = 0;
    int          cycle_count = 0;
    bit          debug_wanted = 1'b0;
    bit          debug_finished = 1'b0;

    // Scan-out monitor state
    logic prev_enable = 1'b0;
    logic prev_hsync = 1'b1;
    logic prev_vsync = 1'b1;
    int   col = 0;
    int   line = 0;
    int   hsync_low = 0;
    int   vsync_low = 0;
    bit   scan_valid = 1'b0;
    bit   scan_debug = 1'b0;
    int   exp_frame = 0;
    int   alt_frame = 0;

    always #(display_period / 2) clk_display = !clk_display;
    always #(system_period / 2) clk_system = !clk_system;

    pipeline_tail dut_i (
        .clk_system                (clk_system),
        .rstn_system               (rstn_system),
        .clk_display               (clk_display),
        .rstn_display              (rstn_display),
        .pixel_valid               (pixel_valid),
        .pixel_ready               (pixel_ready),
        .pixel_color               (pixel_color),
        .pixel_x                   (pixel_x),
        .pixel_y                   (pixel_y),
        .pixel_last                (pixel_last),
        .vga_hsync                 (vga_hsync),
        .vga_vsync                 (vga_vsync),
        .screen_data_enable        (screen_data_enable),
        .vga_red                   (vga_red),
        .vga_green                 (vga_green),
        .vga_blue                  (vga_blue),
        .debug_active_frame_buffer (debug_active_frame_buffer)
    );

    //////////////////////////////////////////////////
    // Random source
    //////////////////////////////////////////////////

    // Galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    //////////////////////////////////////////////////
    // Pixel stream
    //////////////////////////////////////////////////

    task automatic send_frame(input int frame);
        logic [color_width-1:0] color;
        for (int y = 0; y < buf_height; y++) begin
            for (int x = 0; x < buf_width; x++) begin
                color = color_width'(random_bits(color_width));
                model[frame][y * buf_width + x] = color;
                // Random idle cycles ahead of each pixel
                while (random_bits(1) == 1) begin
                    pixel_valid <= 1'b0;
                    @(posedge clk_system);
                end
                pixel_valid <= 1'b1;
                pixel_color <= color;
                pixel_x     <= x_width'(x);
                pixel_y     <= y_width'(y);
                pixel_last  <= (x == buf_width - 1) && (y == buf_height - 1);
                @(posedge clk_system);
                while (!pixel_ready) begin
                    @(posedge clk_system);
                end
            end
        end
        pixel_valid <= 1'b0;
        pixel_last  <= 1'b0;
        done_time[frame] = $time;
        frames_done = frame + 1;
    endtask

    task automatic wait_for_ack(input int frame);
        int cycles;
        cycles = 0;
        @(posedge clk_system);
        if (pixel_ready !== 1'b0) begin
            $display("Error at time %0t: pixel_ready high after last pixel of frame %0d",
                     $time, frame);
            error_count++;
        end
        while (pixel_ready !== 1'b1 && cycles < ack_limit) begin
            @(posedge clk_system);
            cycles++;
        end
        if (pixel_ready !== 1'b1) begin
            $display("Frame %0d was not acknowledged within two scan frames", frame);
            error_count++;
        end
    endtask

    //////////////////////////////////////////////////
    // Scan-out monitor
    //////////////////////////////////////////////////

    // Picks the frame the coming scan must show, and steps the debug view
    task automatic choose_expected_frame();
        int settled;
        int latest;
        settled = -1;
        latest  = -1;
        for (int i = 0; i < frames_done; i++) begin
            if (done_time[i] + settle_time <= $time) settled = i;
            if (done_time[i] < $time) latest = i;
        end
        scan_debug = 1'b0;
        if (debug_active_frame_buffer) begin
            debug_active_frame_buffer <= 1'b0;
            debug_finished = 1'b1;
        end else if (debug_wanted) begin
            debug_active_frame_buffer <= 1'b1;
            debug_wanted = 1'b0;
            scan_debug = 1'b1;
            // Frame before the shown one is still in the drawing buffer
            settled = settled - 1;
            latest  = settled;
        end
        scan_valid = (settled >= 0);
        exp_frame  = (settled >= 0) ? settled : 0;
        alt_frame  = (latest >= 0) ? latest : 0;
    endtask

    always @(posedge clk_display) begin : scan_monitor
        logic [color_width-1:0] pixel;
        int                     addr;
        if (rstn_display) begin
            pixel = {vga_red, vga_green, vga_blue};
            addr  = (line / 2) * buf_width + col / 2;
            if (!screen_data_enable && pixel !== '0) begin
                $display("Error at time %0t: colour %h outside the active area", $time, pixel);
                error_count++;
            end
            if (screen_data_enable) begin
                if (scan_valid && col < h_active && line < v_active) begin
                    if (pixel !== model[exp_frame][addr] && pixel !== model[alt_frame][addr]) begin
                        $display("Error at time %0t: line %0d col %0d shows %h, expected %h",
                                 $time, line, col, pixel, model[exp_frame][addr]);
                        error_count++;
                    end
                    checked_pixels++;
                    if (scan_debug) debug_pixels++;
                end
                col++;
            end else if (prev_enable) begin
                if (col != h_active) begin
                    $display("Error at time %0t: line had %0d enabled pixels", $time, col);
                    error_count++;
                end
                col = 0;
                line++;
            end
            if (vga_hsync == h_sync_active) begin
                hsync_low++;
            end else if (prev_hsync == h_sync_active) begin
                if (hsync_low != h_sync) begin
                    $display("Error at time %0t: hsync pulse of %0d cycles", $time, hsync_low);
                    error_count++;
                end
                hsync_low = 0;
            end
            if (vga_vsync == v_sync_active) begin
                vsync_low++;
                // Leading edge closes one scan and opens the next
                if (prev_vsync != v_sync_active) begin
                    if (line != v_active) begin
                        $display("Error at time %0t: frame had %0d enabled lines", $time, line);
                        error_count++;
                    end
                    line = 0;
                    vsync_edges++;
                    choose_expected_frame();
                end
            end else if (prev_vsync == v_sync_active) begin
                if (vsync_low != v_sync * h_total) begin
                    $display("Error at time %0t: vsync pulse of %0d cycles", $time, vsync_low);
                    error_count++;
                end
                vsync_low = 0;
            end
            prev_enable = screen_data_enable;
            prev_hsync  = vga_hsync;
            prev_vsync  = vga_vsync;
        end
    end

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    task automatic print_summary();
        $display("Summary: %0d errors, %0d pixels compared, %0d in the debug scan",
                 error_count, checked_pixels, debug_pixels);
    endtask

    always @(posedge clk_display) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d display cycles", timeout_cycles);
            print_summary();
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : stimulus
        int edges_seen;
        rstn_system               = 1'b0;
        rstn_display              = 1'b0;
        pixel_valid               = 1'b0;
        pixel_color               = '0;
        pixel_x                   = '0;
        pixel_y                   = '0;
        pixel_last                = 1'b0;
        debug_active_frame_buffer = 1'b0;
        repeat (2) @(posedge clk_display);
        rstn_display <= 1'b1;
        rstn_system  <= 1'b1;
        @(posedge clk_system);
        for (int frame = 0; frame < frame_count; frame++) begin
            send_frame(frame);
            wait_for_ack(frame);
            // One scan of the drawing buffer while the input stays idle
            if (frame == 2) begin
                debug_wanted = 1'b1;
                while (!debug_finished) begin
                    @(posedge clk_system);
                end
            end
        end
        // Let the last frame go through a full scan
        edges_seen = vsync_edges;
        while (vsync_edges == edges_seen) begin
            @(posedge clk_system);
        end
        if (checked_pixels == 0) begin
            $display("No visible pixel was compared against the model");
            error_count++;
        end
        if (debug_pixels != h_active * v_active) begin
            $display("Debug scan compared %0d pixels instead of %0d",
                     debug_pixels, h_active * v_active);
            error_count++;
        end
        print_summary();
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: design/pipeline_tail.sv
`timescale 1ns/100ps

module pipeline_tail (
    input  logic                                      clk_system,
    input  logic                                      rstn_system,
    input  logic                                      clk_display,
    input  logic                                      rstn_display,

    // Pixel stream, system domain
    input  logic                                      pixel_valid,
    output logic                                      pixel_ready,
    input  logic [display_tail_pkg::color_width-1:0]  pixel_color,
    input  logic [display_tail_pkg::x_width-1:0]      pixel_x,
    input  logic [display_tail_pkg::y_width-1:0]      pixel_y,
    input  logic                                      pixel_last,

    // Display output, display domain
    output logic                                      vga_hsync,
    output logic                                      vga_vsync,
    output logic                                      screen_data_enable,
    output logic [display_tail_pkg::red_width-1:0]    vga_red,
    output logic [display_tail_pkg::green_width-1:0]  vga_green,
    output logic [display_tail_pkg::blue_width-1:0]   vga_blue,

    input  logic                                      debug_active_frame_buffer
);

    import display_tail_pkg::*;

    logic                      write_en;
    logic [buf_addr_width-1:0] write_addr;
    logic [color_width-1:0]    write_data;
    logic                      write_en_a;
    logic                      write_en_b;
    logic                      frame_done;
    logic                      draw_ack;
    logic [buf_addr_width-1:0] read_addr;
    logic [color_width-1:0]    read_data_a;
    logic [color_width-1:0]    read_data_b;
    logic [color_width-1:0]    read_data;

    // 0 shows buffer A and draws into B
    logic buffer_select;
    logic buffer_select_meta;
    logic buffer_select_sys;
    logic frame_done_meta;
    logic frame_done_disp;
    logic vsync_d;
    logic swap_req;

    //////////////////////////////////////////////////
    // Swap control, display domain
    //////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            frame_done_meta <= 1'b0;
            frame_done_disp <= 1'b0;
            vsync_d         <= !v_sync_active;
            buffer_select   <= 1'b0;
        end else begin
            frame_done_meta <= frame_done;
            frame_done_disp <= frame_done_meta;
            vsync_d         <= vga_vsync;
            if (swap_req) begin
                buffer_select <= !buffer_select;
            end
        end
    end

    // Swap at the vsync leading edge, only with a finished frame waiting
    assign swap_req = (vga_vsync == v_sync_active) && (vsync_d != v_sync_active)
                   && frame_done_disp;

    // Debug flips the view over to the drawing buffer
    assign read_data = (buffer_select ^ debug_active_frame_buffer) ? read_data_b : read_data_a;

    //////////////////////////////////////////////////
    // Write routing, system domain
    //////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            buffer_select_meta <= 1'b0;
            buffer_select_sys  <= 1'b0;
        end else begin
            buffer_select_meta <= buffer_select;
            buffer_select_sys  <= buffer_select_meta;
        end
    end

    assign write_en_a = write_en && buffer_select_sys;
    assign write_en_b = write_en && !buffer_select_sys;

    drawing_manager drawing_manager_i (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .pixel_valid (pixel_valid),
        .pixel_ready (pixel_ready),
        .pixel_color (pixel_color),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .pixel_last  (pixel_last),
        .write_en    (write_en),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .frame_done  (frame_done),
        .draw_ack    (draw_ack)
    );

    frame_buffer buffer_a_i (
        .clk_system  (clk_system),
        .write_en    (write_en_a),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .clk_display (clk_display),
        .read_addr   (read_addr),
        .read_data   (read_data_a)
    );

    frame_buffer buffer_b_i (
        .clk_system  (clk_system),
        .write_en    (write_en_b),
        .write_addr  (write_addr),
        .write_data  (write_data),
        .clk_display (clk_display),
        .read_addr   (read_addr),
        .read_data   (read_data_b)
    );

    display_scanout display_scanout_i (
        .clk_display        (clk_display),
        .rstn_display       (rstn_display),
        .read_addr          (read_addr),
        .read_data          (read_data),
        .vga_hsync          (vga_hsync),
        .vga_vsync          (vga_vsync),
        .screen_data_enable (screen_data_enable),
        .vga_red            (vga_red),
        .vga_green          (vga_green),
        .vga_blue           (vga_blue)
    );

    // Acknowledge travels back as a pulse
    pulse_sync draw_ack_sync_i (
        .clk_src   (clk_display),
        .rstn_src  (rstn_display),
        .pulse_in  (swap_req),
        .clk_dst   (clk_system),
        .rstn_dst  (rstn_system),
        .pulse_out (draw_ack)
    );

    // A swap inside the visible area would tear the shown frame
    a_swap_in_blank: assert property (@(posedge clk_display) disable iff (!rstn_display)
        swap_req |-> !screen_data_enable)
        else $error("pipeline_tail: buffer swap during visible area");

endmodule

// File: design/display_scanout.sv
`timescale 1ns/100ps

module display_scanout (
    input  logic                                         clk_display,
    input  logic                                         rstn_display,

    // Frame buffer read
    output logic [display_tail_pkg::buf_addr_width-1:0]  read_addr,
    input  logic [display_tail_pkg::color_width-1:0]     read_data,

    // VGA style output
    output logic                                         vga_hsync,
    output logic                                         vga_vsync,
    output logic                                         screen_data_enable,
    output logic [display_tail_pkg::red_width-1:0]       vga_red,
    output logic [display_tail_pkg::green_width-1:0]     vga_green,
    output logic [display_tail_pkg::blue_width-1:0]      vga_blue
);

    import display_tail_pkg::*;

    logic [$clog2(h_total)-1:0] h_count;
    logic [$clog2(v_total)-1:0] v_count;
    logic                       active;
    logic                       hsync_now;
    logic                       vsync_now;
    logic                       active_d;
    logic                       hsync_d;
    logic                       vsync_d;

    //////////////////////////////////////////////////
    // Scan position
    //////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == h_total - 1) begin
            h_count <= '0;
            if (v_count == v_total - 1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 1'b1;
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    // Active area first, then front porch, sync and back porch
    assign active    = (h_count < h_active) && (v_count < v_active);
    assign hsync_now = (h_count >= h_active + h_front)
                    && (h_count < h_active + h_front + h_sync);
    assign vsync_now = (v_count >= v_active + v_front)
                    && (v_count < v_active + v_front + v_sync);

    // Half column and half line give the 2x2 pixel doubling
    assign read_addr = active
        ? buf_addr_width'(v_count >> 1) * buf_addr_width'(buf_width)
          + buf_addr_width'(h_count >> 1)
        : '0;

    //////////////////////////////////////////////////
    // Output pipeline
    //////////////////////////////////////////////////

    // Stage 1 runs beside the memory read, stage 2 drives the pins
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            active_d           <= 1'b0;
            hsync_d            <= !h_sync_active;
            vsync_d            <= !v_sync_active;
            screen_data_enable <= 1'b0;
            vga_hsync          <= !h_sync_active;
            vga_vsync          <= !v_sync_active;
            vga_red            <= '0;
            vga_green          <= '0;
            vga_blue           <= '0;
        end else begin
            active_d           <= active;
            hsync_d            <= hsync_now ? h_sync_active : !h_sync_active;
            vsync_d            <= vsync_now ? v_sync_active : !v_sync_active;
            screen_data_enable <= active_d;
            vga_hsync          <= hsync_d;
            vga_vsync          <= vsync_d;
            // Blank outside the visible area
            if (active_d) begin
                vga_red   <= read_data[color_width-1 -: red_width];
                vga_green <= read_data[blue_width +: green_width];
                vga_blue  <= read_data[blue_width-1:0];
            end else begin
                vga_red   <= '0;
                vga_green <= '0;
                vga_blue  <= '0;
            end
        end
    end

endmodule

// File: design/frame_buffer.sv
`timescale 1ns/100ps

module frame_buffer (
    // Write port, system domain
    input  logic                                         clk_system,
    input  logic                                         write_en,
    input  logic [display_tail_pkg::buf_addr_width-1:0]  write_addr,
    input  logic [display_tail_pkg::color_width-1:0]     write_data,

    // Read port, display domain
    input  logic                                         clk_display,
    input  logic [display_tail_pkg::buf_addr_width-1:0]  read_addr,
    output logic [display_tail_pkg::color_width-1:0]     read_data
);

    import display_tail_pkg::*;

    // One word per buffer pixel
    logic [color_width-1:0] mem [buf_depth];

    always_ff @(posedge clk_system) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read, data one display cycle after the address
    always_ff @(posedge clk_display) begin
        read_data <= mem[read_addr];
    end

endmodule

// File: design/drawing_manager.sv
`timescale 1ns/100ps

module drawing_manager (
    input  logic                                         clk_system,
    input  logic                                         rstn_system,

    // Pixel stream from the rasterizer
    input  logic                                         pixel_valid,
    output logic                                         pixel_ready,
    input  logic [display_tail_pkg::color_width-1:0]     pixel_color,
    input  logic [display_tail_pkg::x_width-1:0]         pixel_x,
    input  logic [display_tail_pkg::y_width-1:0]         pixel_y,
    input  logic                                         pixel_last,

    // Write port towards the drawing buffer
    output logic                                         write_en,
    output logic [display_tail_pkg::buf_addr_width-1:0]  write_addr,
    output logic [display_tail_pkg::color_width-1:0]     write_data,

    // Frame exchange with the display side
    output logic                                         frame_done,
    input  logic                                         draw_ack
);

    import display_tail_pkg::*;

    logic                      pixel_fire;
    logic [buf_addr_width-1:0] pixel_addr;

    assign pixel_fire = pixel_valid && pixel_ready;

    // Row major layout, row times buffer width plus column
    assign pixel_addr = buf_addr_width'(pixel_y) * buf_addr_width'(buf_width)
                      + buf_addr_width'(pixel_x);

    //////////////////////////////////////////////////
    // Buffer write
    //////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            write_en <= 1'b0;
        end else begin
            write_en <= pixel_fire;
        end
    end

    always_ff @(posedge clk_system) begin
        if (pixel_fire) begin
            write_addr <= pixel_addr;
            write_data <= pixel_color;
        end
    end

    //////////////////////////////////////////////////
    // Frame done / acknowledge
    //////////////////////////////////////////////////

    // Held until the display has swapped buffers
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            frame_done <= 1'b0;
        end else if (pixel_fire && pixel_last) begin
            frame_done <= 1'b1;
        end else if (draw_ack) begin
            frame_done <= 1'b0;
        end
    end

    // Stream closed while a finished frame waits for its swap
    assign pixel_ready = !frame_done;

    a_coord_in_range: assert property (@(posedge clk_system) disable iff (!rstn_system)
        pixel_fire |-> pixel_y < buf_height)
        else $error("drawing_manager: pixel coordinate outside the buffer");

    // An acknowledge only ever answers a pending frame
    a_ack_after_done: assert property (@(posedge clk_system) disable iff (!rstn_system)
        draw_ack |-> frame_done)
        else $error("drawing_manager: draw_ack without a finished frame");

endmodule

// File: design/pulse_sync.sv
`timescale 1ns/100ps

module pulse_sync (
    input  logic clk_src,
    input  logic rstn_src,
    input  logic pulse_in,
    input  logic clk_dst,
    input  logic rstn_dst,
    output logic pulse_out
);

    logic       toggle_src;
    logic [2:0] toggle_dst;

    // Each source pulse flips the level that crosses over
    always_ff @(posedge clk_src or negedge rstn_src) begin
        if (!rstn_src) begin
            toggle_src <= 1'b0;
        end else if (pulse_in) begin
            toggle_src <= !toggle_src;
        end
    end

    // First two stages resolve metastability, third keeps the old level
    always_ff @(posedge clk_dst or negedge rstn_dst) begin
        if (!rstn_dst) begin
            toggle_dst <= '0;
        end else begin
            toggle_dst <= {toggle_dst[1:0], toggle_src};
        end
    end

    // Level change seen in the destination gives one cycle out
    assign pulse_out = toggle_dst[2] ^ toggle_dst[1];

    // Closer pulses could merge before the destination sees the change
    a_pulse_spacing: assert property (@(posedge clk_src) disable iff (!rstn_src)
        pulse_in |=> !pulse_in [*3])
        else $error("pulse_sync: source pulses closer than 4 cycles");

endmodule

// File: design/display_tail_pkg.sv
package display_tail_pkg;

    //////////////////////////////////////////////////
    // Frame buffer geometry
    //////////////////////////////////////////////////

    localparam int buf_width      = 16;
    localparam int buf_height     = 12;
    localparam int buf_depth      = buf_width * buf_height;
    localparam int buf_addr_width = $clog2(buf_depth);

    // Pixel coordinates as sent by the rasterizer
    localparam int x_width = $clog2(buf_width);
    localparam int y_width = $clog2(buf_height);

    //////////////////////////////////////////////////
    // Colour format
    //////////////////////////////////////////////////

    // Stored word is {red, green, blue}, blue in the low bits
    localparam int red_width   = 4;
    localparam int green_width = 4;
    localparam int blue_width  = 4;
    localparam int color_width = red_width + green_width + blue_width;

    //////////////////////////////////////////////////
    // Video timing
    //////////////////////////////////////////////////

    // Tiny mode for simulation, each buffer pixel shown as 2x2
    localparam int h_active = 2 * buf_width;
    localparam int h_front  = 2;
    localparam int h_sync   = 4;
    localparam int h_back   = 2;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    localparam int v_active = 2 * buf_height;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 1;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    // Negative polarity on both syncs
    localparam logic h_sync_active = 1'b0;
    localparam logic v_sync_active = 1'b0;

endpackage
